// File: src/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// word size and multiply/divide iterations
`define EX_DATA_WIDTH 32
`define EX_MD_STEPS   32

// SPECIAL funct codes
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SLLV  6'b000100
`define FUNCT_SRLV  6'b000110
`define FUNCT_SRAV  6'b000111
`define FUNCT_JR    6'b001000
`define FUNCT_MOVZ  6'b001010
`define FUNCT_MOVN  6'b001011
`define FUNCT_MFHI  6'b010000
`define FUNCT_MTHI  6'b010001
`define FUNCT_MFLO  6'b010010
`define FUNCT_MTLO  6'b010011
`define FUNCT_MULT  6'b011000
`define FUNCT_MULTU 6'b011001
`define FUNCT_DIV   6'b011010
`define FUNCT_DIVU  6'b011011
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

// SPECIAL2 funct codes
`define FUNCT2_CLZ  6'b100000
`define FUNCT2_CLO  6'b100001

`endif

// File: src/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_DATA_WIDTH-1:0]     word_t;
    typedef logic [2*`EX_DATA_WIDTH-1:0]   dword_t;
    typedef logic [5:0]                    funct_t;
    typedef logic [4:0]                    shamt_t;
    typedef logic [4:0]                    reg_addr_t;
    typedef logic [$clog2(`EX_MD_STEPS)-1:0] step_t;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_DONE
    } md_state_t;

    // one decoded instruction entering the stage
    typedef struct packed {
        logic      special2;
        funct_t    funct;
        shamt_t    shamt;
        word_t     operand_1;
        word_t     operand_2;
        logic      write_reg_en;
        reg_addr_t write_reg_addr;
    } ex_req_t;

    typedef struct packed {
        word_t     result;
        logic      write_reg_en;
        reg_addr_t write_reg_addr;
    } ex_wb_t;

    // hi sits in the upper word
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    typedef struct packed {
        logic div_op;
        logic signed_op;
    } md_cmd_t;

endpackage

// File: src/bit_counter.sv
`timescale 1ns/100ps
`include "ex_settings.svh"

module bit_counter (
    input  logic          count_ones,
    input  ex_pkg::word_t value,
    output ex_pkg::word_t count
);
    import ex_pkg::*;

    word_t scan;

    // leading ones become leading zeros after inversion
    assign scan = count_ones ? ~value : value;

    // highest set bit wins, so the scan runs upward
    always_comb begin
        count = word_t'(`EX_DATA_WIDTH);
        for (int i = 0; i < `EX_DATA_WIDTH; i++) begin
            if (scan[i]) begin
                count = word_t'(`EX_DATA_WIDTH - 1 - i);
            end
        end
    end

endmodule

// File: src/ex_alu.sv
`timescale 1ns/100ps
`include "ex_settings.svh"

module ex_alu (
    input  ex_pkg::ex_req_t req,
    input  ex_pkg::hilo_t   hilo,
    input  ex_pkg::dword_t  md_result,
    input  logic            md_done,
    output ex_pkg::ex_wb_t  wb,
    output logic            overflow,
    output logic            hilo_write_en,
    output ex_pkg::hilo_t   hilo_next,
    output logic            md_req,
    output ex_pkg::md_cmd_t md_cmd,
    output logic            stall_request
);
    import ex_pkg::*;

    logic  is_special;
    logic  is_add_sub;
    logic  overflow_sum;
    logic  op1_lt_op2;
    logic  write_en;
    word_t operand_2_mux;
    word_t result_sum;
    word_t count_result;
    word_t result;

    // sign bits are shifted in from the top
    function automatic word_t shift_arith(word_t value, shamt_t amount);
        return ({`EX_DATA_WIDTH{value[`EX_DATA_WIDTH-1]}} << (6'd32 - {1'b0, amount}))
            | (value >> amount);
    endfunction

    assign is_special = !req.special2;
    assign is_add_sub = is_special
        && (req.funct == `FUNCT_ADD || req.funct == `FUNCT_SUB);

    // subtract as add of the two's complement
    assign operand_2_mux = (is_special && (req.funct == `FUNCT_SUB
        || req.funct == `FUNCT_SUBU || req.funct == `FUNCT_SLT))
        ? (~req.operand_2) + 1'b1 : req.operand_2;
    assign result_sum = req.operand_1 + operand_2_mux;

    assign overflow_sum = (!req.operand_1[31] && !operand_2_mux[31] && result_sum[31])
        || (req.operand_1[31] && operand_2_mux[31] && !result_sum[31]);
    assign overflow = is_add_sub && overflow_sum;

    // signed rule looks at both signs and the difference
    assign op1_lt_op2 = (req.funct == `FUNCT_SLT)
        ? ((req.operand_1[31] && !req.operand_2[31])
            || (!req.operand_1[31] && !req.operand_2[31] && result_sum[31])
            || (req.operand_1[31] && req.operand_2[31] && result_sum[31]))
        : (req.operand_1 < req.operand_2);

    bit_counter bit_counter0 (
        .count_ones (req.funct == `FUNCT2_CLO),
        .value      (req.operand_1),
        .count      (count_result)
    );

    always_comb begin
        result = '0;
        if (req.special2) begin
            case (req.funct)
                `FUNCT2_CLZ, `FUNCT2_CLO: result = count_result;
                default: result = '0;
            endcase
        end else begin
            case (req.funct)
                `FUNCT_AND: result = req.operand_1 & req.operand_2;
                `FUNCT_OR:  result = req.operand_1 | req.operand_2;
                `FUNCT_XOR: result = req.operand_1 ^ req.operand_2;
                `FUNCT_NOR: result = ~(req.operand_1 | req.operand_2);
                `FUNCT_ADD, `FUNCT_ADDU,
                `FUNCT_SUB, `FUNCT_SUBU: result = result_sum;
                `FUNCT_SLT, `FUNCT_SLTU: result = word_t'(op1_lt_op2);
                `FUNCT_MOVN, `FUNCT_MOVZ: result = req.operand_1;
                `FUNCT_MFHI: result = hilo.hi;
                `FUNCT_MFLO: result = hilo.lo;
                `FUNCT_SLL:  result = req.operand_2 << req.shamt;
                `FUNCT_SRL:  result = req.operand_2 >> req.shamt;
                `FUNCT_SRA:  result = shift_arith(req.operand_2, req.shamt);
                `FUNCT_SLLV: result = req.operand_2 << req.operand_1[4:0];
                `FUNCT_SRLV: result = req.operand_2 >> req.operand_1[4:0];
                `FUNCT_SRAV: result = shift_arith(req.operand_2, req.operand_1[4:0]);
                default: result = '0;
            endcase
        end
    end

    // register write decision
    always_comb begin
        write_en = req.write_reg_en;
        if (is_special) begin
            case (req.funct)
                `FUNCT_ADD, `FUNCT_SUB: write_en = req.write_reg_en && !overflow_sum;
                `FUNCT_MULT, `FUNCT_MULTU, `FUNCT_DIV, `FUNCT_DIVU,
                `FUNCT_MTHI, `FUNCT_MTLO, `FUNCT_JR: write_en = 1'b0;
                `FUNCT_MOVN: write_en = req.write_reg_en && (req.operand_2 != '0);
                `FUNCT_MOVZ: write_en = req.write_reg_en && (req.operand_2 == '0);
                default: write_en = req.write_reg_en;
            endcase
        end
    end

    assign wb = '{result: result, write_reg_en: write_en,
                  write_reg_addr: req.write_reg_addr};

    assign md_req = is_special && (req.funct == `FUNCT_MULT || req.funct == `FUNCT_MULTU
        || req.funct == `FUNCT_DIV || req.funct == `FUNCT_DIVU);
    assign md_cmd.div_op = req.funct == `FUNCT_DIV || req.funct == `FUNCT_DIVU;
    assign md_cmd.signed_op = req.funct == `FUNCT_MULT || req.funct == `FUNCT_DIV;

    // HI/LO update selection
    always_comb begin
        hilo_write_en = 1'b0;
        hilo_next = hilo;
        if (is_special) begin
            case (req.funct)
                `FUNCT_MTHI: begin
                    hilo_write_en = 1'b1;
                    hilo_next.hi = req.operand_1;
                end
                `FUNCT_MTLO: begin
                    hilo_write_en = 1'b1;
                    hilo_next.lo = req.operand_1;
                end
                `FUNCT_MULT, `FUNCT_MULTU, `FUNCT_DIV, `FUNCT_DIVU: begin
                    hilo_write_en = md_done;
                    hilo_next = hilo_t'(md_result);
                end
                default: hilo_write_en = 1'b0;
            endcase
        end
    end

    assign stall_request = md_req && !md_done;

    // controller only finishes while the request is still held
    md_hilo_write: assert final (md_done == (md_req && hilo_write_en))
        else $error("md_done out of step with multiply/divide HI/LO write");

endmodule

// File: src/muldiv_ctrl.sv
`timescale 1ns/100ps

module muldiv_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic md_req,
    input  logic last_step,
    output logic start,
    output logic step_en,
    output logic md_done
);
    import ex_pkg::*;

    md_state_t state;
    md_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            MD_IDLE: begin
                if (md_req) begin
                    state_next = MD_RUN;
                end
            end
            MD_RUN: begin
                if (last_step) begin
                    state_next = MD_DONE;
                end
            end
            MD_DONE: state_next = MD_IDLE;
            default: state_next = MD_IDLE;
        endcase
    end

    // operands are captured in the idle cycle
    assign start = (state == MD_IDLE) && md_req;
    assign step_en = (state == MD_RUN);
    assign md_done = (state == MD_DONE);

    // request stays held until the done cycle
    md_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        state != MD_IDLE |-> md_req);

endmodule

// File: src/muldiv_step_counter.sv
`timescale 1ns/100ps
`include "ex_settings.svh"

module muldiv_step_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic step_en,
    output logic last_step
);
    import ex_pkg::*;

    step_t step;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
        end else if (start) begin
            step <= '0;
        end else if (step_en) begin
            step <= step + 1'b1;
        end
    end

    assign last_step = (step == step_t'(`EX_MD_STEPS - 1));

endmodule

// File: src/muldiv_datapath.sv
`timescale 1ns/100ps
`include "ex_settings.svh"

module muldiv_datapath (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            step_en,
    input  ex_pkg::md_cmd_t cmd,
    input  ex_pkg::word_t   operand_1,
    input  ex_pkg::word_t   operand_2,
    output ex_pkg::dword_t  md_result
);
    import ex_pkg::*;

    md_cmd_t cmd_q;
    // product or quotient is negative
    logic    neg_lo_q;
    // remainder follows the dividend
    logic    neg_hi_q;
    logic    div_zero_q;
    word_t   mag_1;
    word_t   mag_2;
    // multiplicand or divisor magnitude
    word_t   mag_2_q;
    // hi is partial product or remainder, lo is multiplier or quotient
    dword_t  acc;
    dword_t  acc_next;
    logic [`EX_DATA_WIDTH:0] mul_sum;
    logic [`EX_DATA_WIDTH:0] div_shift;
    logic [`EX_DATA_WIDTH:0] div_diff;
    word_t   rem;
    word_t   quot;

    assign mag_1 = (cmd.signed_op && operand_1[31]) ? -operand_1 : operand_1;
    assign mag_2 = (cmd.signed_op && operand_2[31]) ? -operand_2 : operand_2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_q <= '0;
            neg_lo_q <= 1'b0;
            neg_hi_q <= 1'b0;
            div_zero_q <= 1'b0;
        end else if (start) begin
            cmd_q <= cmd;
            neg_lo_q <= cmd.signed_op && (operand_1[31] ^ operand_2[31]);
            neg_hi_q <= cmd.signed_op && operand_1[31];
            div_zero_q <= (operand_2 == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mag_2_q <= mag_2;
            acc <= {{`EX_DATA_WIDTH{1'b0}}, mag_1};
        end else if (step_en) begin
            acc <= acc_next;
        end
    end

    // shift-add step and restoring divide step
    always_comb begin
        mul_sum = {1'b0, acc[63:32]} + {1'b0, mag_2_q};
        div_shift = {acc[63:32], acc[31]};
        div_diff = div_shift - {1'b0, mag_2_q};
        if (!cmd_q.div_op) begin
            acc_next = acc[0] ? {mul_sum, acc[31:1]} : {1'b0, acc[63:1]};
        end else if (!div_diff[`EX_DATA_WIDTH]) begin
            acc_next = {div_diff[31:0], acc[30:0], 1'b1};
        end else begin
            acc_next = {div_shift[31:0], acc[30:0], 1'b0};
        end
    end

    // sign fix-up
    // with a zero divisor the remainder comes back as operand_1 anyway
    always_comb begin
        rem = neg_hi_q ? -acc[63:32] : acc[63:32];
        quot = div_zero_q ? '1 : (neg_lo_q ? -acc[31:0] : acc[31:0]);
        if (cmd_q.div_op) begin
            md_result = {rem, quot};
        end else begin
            md_result = neg_lo_q ? -acc : acc;
        end
    end

endmodule

// File: src/hilo_reg.sv
`timescale 1ns/100ps

module hilo_reg (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          write_en,
    input  ex_pkg::hilo_t hilo_next,
    output ex_pkg::hilo_t hilo
);
    import ex_pkg::*;

    // architectural HI/LO pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hilo <= '0;
        end else if (write_en) begin
            hilo <= hilo_next;
        end
    end

endmodule

// File: src/ex_unit.sv
`timescale 1ns/100ps

module ex_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::ex_req_t req,
    output ex_pkg::ex_wb_t  wb,
    output logic            overflow,
    output logic            stall_request
);
    import ex_pkg::*;

    hilo_t   hilo;
    hilo_t   hilo_next;
    logic    hilo_write_en;
    dword_t  md_result;
    md_cmd_t md_cmd;
    logic    md_req;
    logic    md_done;
    logic    start;
    logic    step_en;
    logic    last_step;

    ex_alu ex_alu0 (
        .req           (req),
        .hilo          (hilo),
        .md_result     (md_result),
        .md_done       (md_done),
        .wb            (wb),
        .overflow      (overflow),
        .hilo_write_en (hilo_write_en),
        .hilo_next     (hilo_next),
        .md_req        (md_req),
        .md_cmd        (md_cmd),
        .stall_request (stall_request)
    );

    muldiv_ctrl muldiv_ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_req    (md_req),
        .last_step (last_step),
        .start     (start),
        .step_en   (step_en),
        .md_done   (md_done)
    );

    muldiv_step_counter muldiv_step_counter0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .step_en   (step_en),
        .last_step (last_step)
    );

    muldiv_datapath muldiv_datapath0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .step_en   (step_en),
        .cmd       (md_cmd),
        .operand_1 (req.operand_1),
        .operand_2 (req.operand_2),
        .md_result (md_result)
    );

    hilo_reg hilo_reg0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .write_en  (hilo_write_en),
        .hilo_next (hilo_next),
        .hilo      (hilo)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

// File: tests/tb_ex_unit.sv
`timescale 1ns/100ps
`include "ex_settings.svh"

module tb_ex_unit;
    import ex_pkg::*;

    typedef struct packed {
        ex_req_t    req;
        ex_wb_t     exp_wb;
        logic       exp_overflow;
        logic [7:0] exp_stall;
    } row_t;

    logic    clk;
    logic    rst_n;
    ex_req_t req;
    ex_wb_t  wb;
    logic    overflow;
    logic    stall_request;

    row_t  rows[$];
    word_t model_hi;
    word_t model_lo;
    int    seed;
    int    error_count;
    int    cycle_count;
    int    cycle_limit;

    tb_clock_gen clock_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ex_unit dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .wb            (wb),
        .overflow      (overflow),
        .stall_request (stall_request)
    );

    function automatic dword_t expected_product(word_t a, word_t b, logic is_signed);
        longint sa;
        longint sb;
        sa = is_signed ? longint'($signed(a)) : longint'({32'b0, a});
        sb = is_signed ? longint'($signed(b)) : longint'({32'b0, b});
        return dword_t'(sa * sb);
    endfunction

    // remainder in the upper word, quotient in the lower
    function automatic dword_t expected_divide(word_t a, word_t b, logic is_signed);
        longint sa;
        longint sb;
        longint q;
        longint r;
        if (b == '0) begin
            return {a, 32'hFFFF_FFFF};
        end
        sa = is_signed ? longint'($signed(a)) : longint'({32'b0, a});
        sb = is_signed ? longint'($signed(b)) : longint'({32'b0, b});
        q = sa / sb;
        r = sa % sb;
        return {r[31:0], q[31:0]};
    endfunction

    task automatic add_row(input logic special2, input funct_t funct, input shamt_t shamt,
                           input word_t op1, input word_t op2, input word_t exp_result,
                           input logic exp_wen, input logic exp_ovf, input int exp_stall);
        row_t row;
        logic req_wen;
        // every third request comes without a register write
        req_wen = (rows.size() % 3) != 0;
        row.req = '{special2: special2, funct: funct, shamt: shamt, operand_1: op1,
                    operand_2: op2, write_reg_en: req_wen,
                    write_reg_addr: reg_addr_t'(rows.size() + 1)};
        row.exp_wb = '{result: exp_result, write_reg_en: exp_wen && req_wen,
                       write_reg_addr: row.req.write_reg_addr};
        row.exp_overflow = exp_ovf;
        row.exp_stall = 8'(exp_stall);
        rows.push_back(row);
    endtask

    task automatic add_op(input funct_t funct, input word_t op1, input word_t op2,
                          input word_t exp_result, input logic exp_wen, input logic exp_ovf);
        add_row(1'b0, funct, '0, op1, op2, exp_result, exp_wen, exp_ovf, 0);
    endtask

    // MULT/DIV row then read back through MFHI and MFLO
    task automatic add_md(input funct_t funct, input word_t op1, input word_t op2);
        dword_t expected;
        logic   is_signed;
        is_signed = (funct == `FUNCT_MULT) || (funct == `FUNCT_DIV);
        if (funct == `FUNCT_DIV || funct == `FUNCT_DIVU) begin
            expected = expected_divide(op1, op2, is_signed);
        end else begin
            expected = expected_product(op1, op2, is_signed);
        end
        add_row(1'b0, funct, '0, op1, op2, '0, 1'b0, 1'b0, `EX_MD_STEPS + 1);
        model_hi = expected[63:32];
        model_lo = expected[31:0];
        add_op(`FUNCT_MFHI, '0, '0, model_hi, 1'b1, 1'b0);
        add_op(`FUNCT_MFLO, '0, '0, model_lo, 1'b1, 1'b0);
    endtask

    task automatic add_random_arith(input word_t a, input word_t b);
        longint sum;
        longint diff;
        logic   ovf_add;
        logic   ovf_sub;
        sum = longint'($signed(a)) + longint'($signed(b));
        diff = longint'($signed(a)) - longint'($signed(b));
        ovf_add = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
        ovf_sub = (diff > 64'sd2147483647) || (diff < -64'sd2147483648);
        add_op(`FUNCT_ADD, a, b, a + b, !ovf_add, ovf_add);
        add_op(`FUNCT_SUB, a, b, a - b, !ovf_sub, ovf_sub);
        add_op(`FUNCT_SLT, a, b, word_t'($signed(a) < $signed(b)), 1'b1, 1'b0);
        add_op(`FUNCT_SLTU, a, b, word_t'(a < b), 1'b1, 1'b0);
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        // HI/LO read zero after reset
        add_op(`FUNCT_MFHI, '0, '0, '0, 1'b1, 1'b0);
        add_op(`FUNCT_MFLO, '0, '0, '0, 1'b1, 1'b0);
        add_op(`FUNCT_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b1, 1'b0);
        add_op(`FUNCT_OR, 32'hF000_0000, 32'h0000_000F, 32'hF000_000F, 1'b1, 1'b0);
        add_op(`FUNCT_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F, 1'b1, 1'b0);
        add_op(`FUNCT_NOR, 32'h0000_FFFF, 32'h00FF_0000, 32'hFF00_0000, 1'b1, 1'b0);
        add_row(1'b0, `FUNCT_SLL, 5'd4, '0, 32'h0000_00F1, 32'h0000_0F10, 1'b1, 1'b0, 0);
        add_row(1'b0, `FUNCT_SRL, 5'd8, '0, 32'h8000_1200, 32'h0080_0012, 1'b1, 1'b0, 0);
        add_row(1'b0, `FUNCT_SRA, 5'd4, '0, 32'hF000_0000, 32'hFF00_0000, 1'b1, 1'b0, 0);
        add_row(1'b0, `FUNCT_SRA, 5'd31, '0, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1, 1'b0, 0);
        add_op(`FUNCT_SLLV, 32'd36, 32'h0000_0001, 32'h0000_0010, 1'b1, 1'b0);
        add_op(`FUNCT_SRLV, 32'd3, 32'h0000_0080, 32'h0000_0010, 1'b1, 1'b0);
        add_op(`FUNCT_SRAV, 32'd8, 32'h8000_0000, 32'hFF80_0000, 1'b1, 1'b0);
        add_op(`FUNCT_SLT, 32'hFFFF_FFFF, 32'd1, 32'd1, 1'b1, 1'b0);
        add_op(`FUNCT_SLTU, 32'hFFFF_FFFF, 32'd1, 32'd0, 1'b1, 1'b0);
        add_op(`FUNCT_SLT, 32'd5, 32'd3, 32'd0, 1'b1, 1'b0);
        add_op(`FUNCT_SLT, 32'h8000_0000, 32'h7FFF_FFFF, 32'd1, 1'b1, 1'b0);
        // signed overflow drops the write
        add_op(`FUNCT_ADD, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000, 1'b0, 1'b1);
        add_op(`FUNCT_SUB, 32'h8000_0000, 32'd1, 32'h7FFF_FFFF, 1'b0, 1'b1);
        add_op(`FUNCT_ADDU, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000, 1'b1, 1'b0);
        add_op(`FUNCT_SUBU, 32'h8000_0000, 32'd1, 32'h7FFF_FFFF, 1'b1, 1'b0);
        add_op(`FUNCT_ADD, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b1, 1'b0);
        add_row(1'b1, `FUNCT2_CLZ, '0, 32'h0000_0000, '0, 32'd32, 1'b1, 1'b0, 0);
        add_row(1'b1, `FUNCT2_CLZ, '0, 32'h0001_0000, '0, 32'd15, 1'b1, 1'b0, 0);
        add_row(1'b1, `FUNCT2_CLO, '0, 32'hFFFF_FFFF, '0, 32'd32, 1'b1, 1'b0, 0);
        add_row(1'b1, `FUNCT2_CLO, '0, 32'hF000_0000, '0, 32'd4, 1'b1, 1'b0, 0);
        add_row(1'b1, `FUNCT2_CLO, '0, 32'h0000_0000, '0, 32'd0, 1'b1, 1'b0, 0);
        add_op(`FUNCT_MOVN, 32'h0000_1234, 32'd5, 32'h0000_1234, 1'b1, 1'b0);
        add_op(`FUNCT_MOVN, 32'h0000_1234, 32'd0, 32'h0000_1234, 1'b0, 1'b0);
        add_op(`FUNCT_MOVZ, 32'h0000_5678, 32'd0, 32'h0000_5678, 1'b1, 1'b0);
        add_op(`FUNCT_MOVZ, 32'h0000_5678, 32'd7, 32'h0000_5678, 1'b0, 1'b0);
        // moves to HI/LO give no register result
        add_op(`FUNCT_MTHI, 32'hCAFE_0001, '0, '0, 1'b0, 1'b0);
        add_op(`FUNCT_MTLO, 32'h0BAD_F00D, '0, '0, 1'b0, 1'b0);
        add_op(`FUNCT_MFHI, '0, '0, 32'hCAFE_0001, 1'b1, 1'b0);
        add_op(`FUNCT_MFLO, '0, '0, 32'h0BAD_F00D, 1'b1, 1'b0);
        add_md(`FUNCT_MULT, 32'hFFFF_FFFE, 32'd3);
        add_md(`FUNCT_MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        add_md(`FUNCT_DIV, 32'hFFFF_FFF9, 32'd2);
        add_md(`FUNCT_DIV, 32'd7, 32'hFFFF_FFFE);
        add_md(`FUNCT_DIVU, 32'hFFFF_FFF0, 32'd16);
        add_md(`FUNCT_DIV, 32'hFFFF_FFFB, 32'd0);
        add_md(`FUNCT_DIVU, 32'h0000_1234, 32'd0);
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_random_arith(a, b);
        end
        for (int k = 0; k < 2; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_md(`FUNCT_MULT, a, b);
            add_md(`FUNCT_DIV, a, b);
        end
    endtask

    task automatic check_wb(input string name, input ex_wb_t got, input ex_wb_t expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got result %h wen %b addr %0d, expected %h %b %0d",
                     $time, name, got.result, got.write_reg_en, got.write_reg_addr,
                     expected.result, expected.write_reg_en, expected.write_reg_addr);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, expected);
            error_count++;
        end
    endtask

    // run limit grows with the table
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: stage did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int stall_cycles;
        int errors_before;
        req = '0;
        seed = 32'hbb53;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        model_hi = '0;
        model_lo = '0;
        build_table();
        cycle_limit = rows.size() * 40 + 20;
        wait (rst_n === 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #10;
            req = rows[i].req;
            stall_cycles = 0;
            @(negedge clk);
            while (stall_request) begin
                stall_cycles++;
                @(negedge clk);
            end
            errors_before = error_count;
            check_wb("wb", wb, rows[i].exp_wb);
            check_flag("overflow", overflow, rows[i].exp_overflow);
            check_cycles("stall_request cycles", stall_cycles, int'(rows[i].exp_stall));
            $display("row %0d funct %h special2 %b: %s", i, rows[i].req.funct,
                     rows[i].req.special2, (error_count == errors_before) ? "ok" : "mismatch");
        end
        $display("%0d rows run, %0d errors", rows.size(), error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: ex_unit.f
+incdir+src
src/ex_pkg.sv
src/bit_counter.sv
src/ex_alu.sv
src/muldiv_ctrl.sv
src/muldiv_step_counter.sv
src/muldiv_datapath.sv
src/hilo_reg.sv
src/ex_unit.sv
tests/tb_clock_gen.sv
tests/tb_ex_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the EX stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_ex_unit -f ex_unit.f -o tb_ex_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_ex_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
